/* verilog/tensor_num_pkg.sv */
package tensor_num_pkg;

  ////////////////////////////////////////
  // Number format
  ////////////////////////////////////////

  // Signed fixed point Q16.16
  localparam int DATA_W = 32;
  localparam int FRAC_W = 16;

  // Full width of a magnitude product
  localparam int PROD_W = 2 * DATA_W;

  // One data word
  typedef logic signed [DATA_W-1:0] data_t;

  ////////////////////////////////////////
  // Saturation limits
  ////////////////////////////////////////

  // Largest positive word, just under 32768.0
  localparam data_t DATA_MAX = {1'b0, {(DATA_W-1){1'b1}}};

  // Most negative word, exactly -32768.0
  localparam data_t DATA_MIN = {1'b1, {(DATA_W-1){1'b0}}};

  ////////////////////////////////////////
  // Tensor extents
  ////////////////////////////////////////

  // Extents run 1 to 16, so one extra bit over the index range
  localparam int DIM_W = 5;

  // Extent or running index along i, j or k
  typedef logic [DIM_W-1:0] dim_t;

endpackage

/* verilog/tensor_ctrl_pkg.sv */
package tensor_ctrl_pkg;

  ////////////////////////////////////////
  // Sequencer states
  ////////////////////////////////////////

  // Top level steps, one pass per operand pair
  typedef enum logic [2:0] {
    // Waiting for a command
    IDLE,
    // Waiting for the next element pair
    OPERAND,
    // Multiplier busy
    MULTIPLY,
    // Adder busy
    ACCUMULATE,
    // Holding one result on the output
    RESULT
  } ctrl_state_t;

  ////////////////////////////////////////
  // Multiplier timing
  ////////////////////////////////////////

  // One shift-add step per operand bit
  localparam int MUL_STEPS = 32;

  // Step counter width, must hold MUL_STEPS itself
  localparam int MUL_CNT_W = $clog2(MUL_STEPS + 1);

endpackage

/* verilog/scalar_multiplier.sv */
module scalar_multiplier (
  input  logic                  CLK,
  input  logic                  RST,

  // Control
  input  logic                  start,
  output logic                  ready,

  // Operands and product
  input  tensor_num_pkg::data_t data_a,
  input  tensor_num_pkg::data_t data_b,
  output tensor_num_pkg::data_t result,
  output logic                  overflow
);

  import tensor_num_pkg::*;
  import tensor_ctrl_pkg::*;

  ////////////////////////////////////////
  // Signals
  ////////////////////////////////////////

  // Operand magnitudes
  logic [DATA_W-1:0]        mag_a_in;
  logic [DATA_W-1:0]        mag_b_in;

  // Shift-add state
  logic [PROD_W-1:0]        mcand;
  logic [DATA_W-1:0]        mplier;
  logic [PROD_W-1:0]        prod;
  logic                     neg;
  logic [MUL_CNT_W-1:0]     step_cnt;

  // Next partial product and its truncated and clamped form
  logic [PROD_W-1:0]        prod_next;
  logic [PROD_W-FRAC_W-1:0] prod_int;
  data_t                    sat_val;
  logic                     sat_ovf;
  logic                     last_step;

  ////////////////////////////////////////
  // Body
  ////////////////////////////////////////

  // Two's complement magnitude
  // DATA_MIN maps to 2^31
  assign mag_a_in = data_a[DATA_W-1] ? -data_a : data_a;
  assign mag_b_in = data_b[DATA_W-1] ? -data_b : data_b;

  assign last_step = (step_cnt == MUL_CNT_W'(1));

  always_comb begin
    // Add the shifted multiplicand when the current bit is set
    prod_next = mplier[0] ? prod + mcand : prod;

    // Drop the fraction bits of the magnitude
    // Truncates toward zero once the sign goes back on
    prod_int = prod_next[PROD_W-1:FRAC_W];

    if (!neg) begin
      // Anything at or above bit 31 does not fit
      sat_ovf = |prod_int[PROD_W-FRAC_W-1:DATA_W-1];
      sat_val = sat_ovf ? DATA_MAX : data_t'(prod_int[DATA_W-1:0]);
    end else begin
      // Negative side reaches one step further
      // 2^31 itself still fits
      sat_ovf = (|prod_int[PROD_W-FRAC_W-1:DATA_W]) ||
                (prod_int[DATA_W-1] && (|prod_int[DATA_W-2:0]));
      sat_val = sat_ovf ? DATA_MIN : -data_t'(prod_int[DATA_W-1:0]);
    end
  end

  // Step counter and ready pulse
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      step_cnt <= '0;
      ready    <= 1'b0;
    end else begin
      ready <= 1'b0;
      if (start) begin
        step_cnt <= MUL_CNT_W'(MUL_STEPS);
      end else if (step_cnt != '0) begin
        step_cnt <= step_cnt - MUL_CNT_W'(1);
        // Result lands together with the last step
        if (last_step) begin
          ready <= 1'b1;
        end
      end
    end
  end

  // Operand latch, shift-add datapath and result register
  always_ff @(posedge CLK) begin
    if (start) begin
      mcand  <= PROD_W'(mag_a_in);
      mplier <= mag_b_in;
      prod   <= '0;
      neg    <= data_a[DATA_W-1] ^ data_b[DATA_W-1];
    end else if (step_cnt != '0) begin
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
      prod   <= prod_next;
      if (last_step) begin
        result   <= sat_val;
        overflow <= sat_ovf;
      end
    end
  end

endmodule

/* verilog/scalar_adder.sv */
module scalar_adder (
  input  logic                  CLK,
  input  logic                  RST,

  // Control
  input  logic                  start,
  output logic                  ready,

  // Addends and sum
  input  tensor_num_pkg::data_t data_a,
  input  tensor_num_pkg::data_t data_b,
  output tensor_num_pkg::data_t result,
  output logic                  overflow
);

  import tensor_num_pkg::*;

  ////////////////////////////////////////
  // Signals
  ////////////////////////////////////////

  // Sum with one guard bit
  logic [DATA_W:0] sum_ext;

  // Clamped sum and its flag
  data_t           sat_val;
  logic            sat_ovf;

  ////////////////////////////////////////
  // Body
  ////////////////////////////////////////

  // Sign extend both addends by one bit
  assign sum_ext = {data_a[DATA_W-1], data_a} + {data_b[DATA_W-1], data_b};

  // Guard and sign bits disagree on signed overflow
  assign sat_ovf = sum_ext[DATA_W] ^ sum_ext[DATA_W-1];

  always_comb begin
    if (!sat_ovf) begin
      sat_val = data_t'(sum_ext[DATA_W-1:0]);
    end else if (sum_ext[DATA_W]) begin
      // True sum below the range
      sat_val = DATA_MIN;
    end else begin
      // True sum above the range
      sat_val = DATA_MAX;
    end
  end

  // Ready follows start by one cycle
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      ready <= 1'b0;
    end else begin
      ready <= start;
    end
  end

  // Sum register, held between starts
  always_ff @(posedge CLK) begin
    if (start) begin
      result   <= sat_val;
      overflow <= sat_ovf;
    end
  end

endmodule

/* verilog/tensor_product.sv */
module tensor_product (
  input  logic                  CLK,
  input  logic                  RST,

  // Command channel
  input  logic                  cmd_valid,
  output logic                  cmd_ready,
  input  tensor_num_pkg::dim_t  size_i,
  input  tensor_num_pkg::dim_t  size_j,
  input  tensor_num_pkg::dim_t  size_k,

  // Operand channel
  input  logic                  in_valid,
  output logic                  in_ready,
  input  tensor_num_pkg::data_t data_a,
  input  tensor_num_pkg::data_t data_b,

  // Result channel
  output logic                  out_valid,
  input  logic                  out_ready,
  output tensor_num_pkg::data_t out_data,
  output logic                  out_overflow
);

  import tensor_num_pkg::*;
  import tensor_ctrl_pkg::*;

  ////////////////////////////////////////
  // Signals
  ////////////////////////////////////////

  // Sequencer
  ctrl_state_t state;
  ctrl_state_t state_next;

  // Handshake strobes
  logic        cmd_fire;
  logic        in_fire;
  logic        out_fire;

  // Latched extents and running indices
  dim_t        size_i_q;
  dim_t        size_j_q;
  dim_t        size_k_q;
  dim_t        i_idx;
  dim_t        j_idx;
  dim_t        k_idx;
  logic        last_i;
  logic        last_j;
  logic        last_k;

  // Current operand pair
  data_t       a_q;
  data_t       b_q;

  // Running sum and sticky overflow for one (i, j)
  data_t       acc;
  logic        acc_ovf;

  // Multiplier link
  logic        mul_start;
  logic        mul_ready;
  data_t       mul_result;
  logic        mul_overflow;

  // Adder link
  logic        add_start;
  logic        add_ready;
  data_t       add_result;
  logic        add_overflow;

  ////////////////////////////////////////
  // Handshakes and index limits
  ////////////////////////////////////////

  assign cmd_fire = cmd_valid & cmd_ready;
  assign in_fire  = in_valid & in_ready;
  assign out_fire = out_valid & out_ready;

  assign last_i = (i_idx == size_i_q - dim_t'(1));
  assign last_j = (j_idx == size_j_q - dim_t'(1));
  assign last_k = (k_idx == size_k_q - dim_t'(1));

  // Product goes straight to the adder
  assign add_start = (state == MULTIPLY) & mul_ready;

  // Accumulator is the output word in RESULT
  assign out_data     = acc;
  assign out_overflow = acc_ovf;

  ////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin  // STEP 0
        if (cmd_fire) begin
          state_next = OPERAND;
        end
      end
      OPERAND: begin  // STEP 1
        if (in_fire) begin
          state_next = MULTIPLY;
        end
      end
      MULTIPLY: begin  // STEP 2
        if (mul_ready) begin
          state_next = ACCUMULATE;
        end
      end
      ACCUMULATE: begin  // STEP 3
        // Last k closes the sum for this (i, j)
        if (add_ready) begin
          state_next = last_k ? RESULT : OPERAND;
        end
      end
      RESULT: begin  // STEP 4
        if (out_fire) begin
          state_next = (last_i && last_j) ? IDLE : OPERAND;
        end
      end
      default: begin
        state_next = IDLE;
      end
    endcase
  end

  // State and registered ready/valid outputs
  // Outputs stay low while RST is high
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= IDLE;
      cmd_ready <= 1'b0;
      in_ready  <= 1'b0;
      out_valid <= 1'b0;
      mul_start <= 1'b0;
    end else begin
      state     <= state_next;
      cmd_ready <= (state_next == IDLE);
      in_ready  <= (state_next == OPERAND);
      out_valid <= (state_next == RESULT);
      // One cycle after the operand transfer
      mul_start <= in_fire;
    end
  end

  ////////////////////////////////////////
  // Index counters
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      i_idx <= '0;
      j_idx <= '0;
      k_idx <= '0;
    end else if (cmd_fire) begin
      i_idx <= '0;
      j_idx <= '0;
      k_idx <= '0;
    end else if ((state == ACCUMULATE) && add_ready) begin
      // k innermost
      k_idx <= last_k ? '0 : k_idx + dim_t'(1);
    end else if (out_fire) begin
      // j wraps into i, i past the end only in IDLE
      if (last_j) begin
        j_idx <= '0;
        i_idx <= i_idx + dim_t'(1);
      end else begin
        j_idx <= j_idx + dim_t'(1);
      end
    end
  end

  ////////////////////////////////////////
  // Datapath registers
  ////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (cmd_fire) begin
      size_i_q <= size_i;
      size_j_q <= size_j;
      size_k_q <= size_k;
      acc      <= '0;
      acc_ovf  <= 1'b0;
    end
    if (in_fire) begin
      a_q <= data_a;
      b_q <= data_b;
    end
    if ((state == ACCUMULATE) && add_ready) begin
      // Multiplier still holds its flag at this point
      acc     <= add_result;
      acc_ovf <= acc_ovf | mul_overflow | add_overflow;
    end else if (out_fire) begin
      // Fresh sum for the next (i, j)
      acc     <= '0;
      acc_ovf <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // Arithmetic units
  ////////////////////////////////////////

  scalar_multiplier u_multiplier (
    .CLK     (CLK),
    .RST     (RST),
    .start   (mul_start),
    .ready   (mul_ready),
    .data_a  (a_q),
    .data_b  (b_q),
    .result  (mul_result),
    .overflow(mul_overflow)
  );

  scalar_adder u_adder (
    .CLK     (CLK),
    .RST     (RST),
    .start   (add_start),
    .ready   (add_ready),
    .data_a  (acc),
    .data_b  (mul_result),
    .result  (add_result),
    .overflow(add_overflow)
  );

endmodule

/* verif/tensor_product_tb.sv */
module tensor_product_tb;

  import tensor_num_pkg::*;

  ////////////////////////////////////////
  // Test table
  ////////////////////////////////////////

  // One command per row, expected result count in the last column
  typedef struct packed {
    int size_i;
    int size_j;
    int size_k;
    int op_sel;
    int stall_sel;
    int gap_sel;
    int results;
  } cmd_row_t;

  localparam int NUM_CMDS    = 10;
  localparam int MAX_OPS     = 4096;
  localparam int MAX_RES     = 256;
  localparam int PAIR_CYCLES = 36;
  localparam logic [31:0] SEED = 32'h4727cc5b;

  cmd_row_t cmd_table [NUM_CMDS];

  ////////////////////////////////////////
  // DUT connections
  ////////////////////////////////////////

  logic  CLK;
  logic  RST;
  logic  cmd_valid;
  logic  cmd_ready;
  dim_t  size_i;
  dim_t  size_j;
  dim_t  size_k;
  logic  in_valid;
  logic  in_ready;
  data_t data_a;
  data_t data_b;
  logic  out_valid;
  logic  out_ready;
  data_t out_data;
  logic  out_overflow;

  // Operands and expected results of the running command
  data_t op_a [MAX_OPS];
  data_t op_b [MAX_OPS];
  data_t exp_data [MAX_RES];
  logic  exp_ovf [MAX_RES];

  // Bookkeeping
  int data_errors;
  int flag_errors;
  int count_errors;
  int other_errors;
  int cyc;
  int cycle_count;
  int timeout_limit;
  int seed_ret;

  tensor_product i_dut (
    .CLK         (CLK),
    .RST         (RST),
    .cmd_valid   (cmd_valid),
    .cmd_ready   (cmd_ready),
    .size_i      (size_i),
    .size_j      (size_j),
    .size_k      (size_k),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .data_a      (data_a),
    .data_b      (data_b),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_data    (out_data),
    .out_overflow(out_overflow)
  );

  // 20 unit period
  always #10 CLK = ~CLK;

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
      data_errors++;
      $display("CHECK FAILED time %0t %s expected 0x%08h actual 0x%08h",
               $time, name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      flag_errors++;
      $display("CHECK FAILED time %0t %s expected %b actual %b", $time, name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      count_errors++;
      $display("CHECK FAILED time %0t %s expected %0d actual %0d", $time, name, exp, act);
    end
  endtask

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // Clamp to the Q16.16 range
  function automatic longint clamp_word(input longint v);
    if (v > longint'(DATA_MAX)) begin
      return longint'(DATA_MAX);
    end else if (v < longint'(DATA_MIN)) begin
      return longint'(DATA_MIN);
    end
    return v;
  endfunction

  task automatic build_expected(input cmd_row_t row);
    longint acc;
    longint prod;
    longint sum;
    longint scale;
    logic   ovf;
    int     q;
    int     k;
    int     idx;
    scale = longint'(1) <<< FRAC_W;
    // Results run i outer, j inner; operands k innermost
    for (q = 0; q < row.size_i * row.size_j; q++) begin
      acc = 0;
      ovf = 1'b0;
      for (k = 0; k < row.size_k; k++) begin
        idx  = q * row.size_k + k;
        // Signed division truncates toward zero
        prod = (longint'(op_a[idx]) * longint'(op_b[idx])) / scale;
        if (clamp_word(prod) != prod) ovf = 1'b1;
        prod = clamp_word(prod);
        sum  = acc + prod;
        if (clamp_word(sum) != sum) ovf = 1'b1;
        acc  = clamp_word(sum);
      end
      exp_data[q] = data_t'(acc);
      exp_ovf[q]  = ovf;
    end
  endtask

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////

  task automatic make_operands(input int sel, input int n);
    int p;
    for (p = 0; p < n; p++) begin
      case (sel)
        0: begin
          // Small integers, some negative
          op_a[p] = data_t'(((p % 7) - 3) <<< FRAC_W);
          op_b[p] = data_t'(((p % 5) + 1) <<< FRAC_W);
        end
        1: begin
          // Random within about +-4.0, fraction bits live
          op_a[p] = data_t'($signed($urandom) >>> 13);
          op_b[p] = data_t'($signed($urandom) >>> 13);
        end
        2: begin
          // 30000.0 times +2.0 or -3.0 overflows the product
          op_a[p] = data_t'(30000 <<< FRAC_W);
          op_b[p] = (p % 2 == 0) ? data_t'(2 <<< FRAC_W) : data_t'(-3 <<< FRAC_W);
        end
        3: begin
          // 20000.0 per product, two of them overflow the sum
          op_a[p] = data_t'(200 <<< FRAC_W);
          op_b[p] = data_t'(100 <<< FRAC_W);
        end
        default: begin
          // Random within about +-128.0
          op_a[p] = data_t'($signed($urandom) >>> 8);
          op_b[p] = data_t'($signed($urandom) >>> 8);
        end
      endcase
    end
  endtask

  // Cycles of out_ready low before taking result r
  function automatic int stall_len(input int sel, input int r);
    return (sel == 0) ? 0 : (r * 3 + 1) % 5;
  endfunction

  // Advance to just after the next rising edge
  task automatic step();
    @(posedge CLK);
    #1;
    cyc++;
  endtask

  ////////////////////////////////////////
  // Command driver and result monitor
  ////////////////////////////////////////

  task automatic run_command(input cmd_row_t row);
    int    n_ops;
    int    n_res;
    int    p;
    int    r;
    int    stall_left;
    int    gap_left;
    int    xfer_cyc;
    logic  stalled_prev;
    logic  sent;
    logic  timing_pending;
    logic  ordy;
    data_t held_data;
    logic  held_ovf;
    n_ops = row.size_i * row.size_j * row.size_k;
    n_res = row.size_i * row.size_j;
    make_operands(row.op_sel, n_ops);
    build_expected(row);
    p              = 0;
    r              = 0;
    stall_left     = stall_len(row.stall_sel, 0);
    gap_left       = 0;
    xfer_cyc       = 0;
    stalled_prev   = 1'b0;
    sent           = 1'b0;
    timing_pending = 1'b0;
    held_data      = '0;
    held_ovf       = 1'b0;

    // Command handshake
    while (!cmd_ready) step();
    cmd_valid = 1'b1;
    size_i    = dim_t'(row.size_i);
    size_j    = dim_t'(row.size_j);
    size_k    = dim_t'(row.size_k);
    step();
    cmd_valid = 1'b0;

    // Run until the controller is back in IDLE
    while (!cmd_ready) begin
      // Stalled result must not move
      if (stalled_prev) begin
        check_flag("out_valid (held)", 1'b1, out_valid);
        check_data("out_data (held)", held_data, out_data);
        check_flag("out_overflow (held)", held_ovf, out_overflow);
      end
      if (out_valid && in_ready) begin
        other_errors++;
        $display("Operand channel open while a result is pending at time %0t", $time);
      end

      // Result side
      ordy = 1'b1;
      if (out_valid && stall_left > 0) begin
        ordy = 1'b0;
        stall_left--;
      end
      out_ready    = ordy;
      stalled_prev = out_valid && !ordy;
      held_data    = out_data;
      held_ovf     = out_overflow;
      if (out_valid && ordy) begin
        if (r < n_res) begin
          check_data("out_data", exp_data[r], out_data);
          check_flag("out_overflow", exp_ovf[r], out_overflow);
        end else begin
          other_errors++;
          $display("Result beyond the expected count at time %0t", $time);
        end
        r++;
        stall_left = stall_len(row.stall_sel, r);
      end

      // Pair turnaround, only where the next pair follows directly
      if (in_ready && timing_pending) begin
        check_count("in_ready delay", PAIR_CYCLES, cyc - xfer_cyc);
        timing_pending = 1'b0;
      end

      // Operand side
      if (sent) begin
        in_valid = 1'b0;
        sent     = 1'b0;
      end
      if (!in_valid && p < n_ops) begin
        if (gap_left == 0) begin
          in_valid = 1'b1;
          data_a   = op_a[p];
          data_b   = op_b[p];
        end else if (in_ready) begin
          gap_left--;
        end
      end
      if (in_valid && in_ready) begin
        // Transfer on the coming edge
        timing_pending = ((p % row.size_k) != row.size_k - 1);
        xfer_cyc       = cyc;
        sent           = 1'b1;
        p++;
        gap_left = (row.gap_sel == 0) ? 0 : p % 3;
      end
      step();
    end

    in_valid  = 1'b0;
    out_ready = 1'b1;
    check_count("results per command", row.results, r);
    check_count("operands accepted", n_ops, p);
  endtask

  ////////////////////////////////////////
  // Timeout
  ////////////////////////////////////////

  always @(posedge CLK) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > timeout_limit) begin
      other_errors++;
      $display("Timeout, the run did not finish within %0d cycles", timeout_limit);
      $display("Errors: data %0d, flag %0d, count %0d, other %0d",
               data_errors, flag_errors, count_errors, other_errors);
      $display("Simulation FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    int c;
    int pairs;
    seed_ret     = $urandom(SEED);
    data_errors  = 0;
    flag_errors  = 0;
    count_errors = 0;
    other_errors = 0;
    cyc          = 0;
    cycle_count  = 0;

    //               i   j   k  ops stall gap results
    cmd_table[0] = '{1,  1,  1,  0,  0,   0,  1};
    cmd_table[1] = '{2,  3,  4,  0,  0,   0,  6};
    cmd_table[2] = '{1,  1, 16,  0,  0,   0,  1};
    cmd_table[3] = '{2,  2,  3,  1,  0,   0,  4};
    cmd_table[4] = '{1,  2,  2,  2,  0,   0,  2};
    cmd_table[5] = '{1,  2,  4,  3,  0,   0,  2};
    cmd_table[6] = '{3,  2,  2,  1,  1,   0,  6};
    cmd_table[7] = '{2,  2,  2,  4,  1,   1,  4};
    cmd_table[8] = '{2,  1,  5,  0,  0,   1,  2};
    cmd_table[9] = '{4,  4,  2,  4,  1,   1, 16};

    // 40 cycles per operand pair plus margin
    pairs = 0;
    for (c = 0; c < NUM_CMDS; c++) begin
      pairs += cmd_table[c].size_i * cmd_table[c].size_j * cmd_table[c].size_k;
    end
    timeout_limit = 40 * pairs + 1000;

    CLK       = 1'b0;
    RST       = 1'b1;
    cmd_valid = 1'b0;
    size_i    = '0;
    size_j    = '0;
    size_k    = '0;
    in_valid  = 1'b0;
    data_a    = '0;
    data_b    = '0;
    out_ready = 1'b1;

    repeat (8) @(posedge CLK);
    #1;
    RST = 1'b0;
    step();

    // Idle outputs right after reset
    check_flag("cmd_ready", 1'b1, cmd_ready);
    check_flag("in_ready", 1'b0, in_ready);
    check_flag("out_valid", 1'b0, out_valid);

    for (c = 0; c < NUM_CMDS; c++) begin
      run_command(cmd_table[c]);
    end

    $display("Errors: data %0d, flag %0d, count %0d, other %0d",
             data_errors, flag_errors, count_errors, other_errors);
    if (data_errors + flag_errors + count_errors + other_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* tensor_product.f */
verilog/tensor_num_pkg.sv
verilog/tensor_ctrl_pkg.sv
verilog/scalar_multiplier.sv
verilog/scalar_adder.sv
verilog/tensor_product.sv
verif/tensor_product_tb.sv
